/* dv/user_logic_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module user_logic_checker
    import jtag_user_pkg::*;
(
    input logic    tck,
    input logic    rst_n,
    input logic    commit,
    input logic    end_of_file,
    input logic    session_clear,
    input logic    digit_shift,
    input logic    inbound_valid,
    input result_t result
);

    // One byte gives at most one line event
    commit_not_with_eof: assert property (
        @(posedge tck) disable iff (!rst_n) !(commit && end_of_file)
    ) else $error("commit and end_of_file high in the same cycle");

    clear_zeroes_result: assert property (
        @(posedge tck) disable iff (!rst_n) session_clear |=> (result == '0)
    ) else $error("result not zero after session_clear");

    // A digit is only shifted for a received byte
    shift_needs_byte: assert property (
        @(posedge tck) disable iff (!rst_n) digit_shift |-> $past(inbound_valid)
    ) else $error("digit_shift without a preceding inbound_valid");

endmodule

bind user_logic user_logic_checker checker_i (
    .tck          (tck),
    .rst_n        (rst_n),
    .commit       (commit),
    .end_of_file  (end_of_file),
    .session_clear(session_clear),
    .digit_shift  (digit_shift),
    .inbound_valid(inbound_valid),
    .result       (result)
);

`default_nettype wire

/* dv/user_logic_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module user_logic_tb
    import jtag_user_pkg::*;
();

    // About 3500 cycles of tests with generous margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic tck;
    logic rst_n;
    logic tdi;
    logic test_logic_reset;
    logic ir_is_user;
    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    logic tdo;
    logic alignment_error;

    inbound_data_t tx_q[$];
    result_t       exp_sum;
    logic          model_eof;
    logic [31:0]   lcg_state;
    int            cycles;

    user_logic #(
        .UPSTREAM_BYPASS_BITS(1)
    ) uut (
        .tck             (tck),
        .rst_n           (rst_n),
        .tdi             (tdi),
        .test_logic_reset(test_logic_reset),
        .ir_is_user      (ir_is_user),
        .capture_dr      (capture_dr),
        .shift_dr        (shift_dr),
        .update_dr       (update_dr),
        .tdo             (tdo),
        .alignment_error (alignment_error)
    );

    always #2 tck = ~tck;

    always @(posedge tck) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, tests did not finish", cycles);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic compare_result(input string name, input result_t got, input result_t exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int hex_value(input inbound_data_t c);
        if (c >= "0" && c <= "9") return int'(c) - 48;
        if (c >= "a" && c <= "f") return int'(c) - 87;
        if (c >= "A" && c <= "F") return int'(c) - 55;
        return -1;
    endfunction

    // Reference model: set bits of a line, zero if the line is rejected
    function automatic int line_weight(input string s);
        int   digits;
        int   ones;
        int   v;
        logic bad;
        digits = 0;
        ones   = 0;
        bad    = 1'b0;
        for (int i = 0; i < s.len(); i++) begin
            v = hex_value(inbound_data_t'(s[i]));
            if (v >= 0) begin
                digits++;
                for (int b = 0; b < 4; b++) ones += (v >> b) & 1;
            end else if (inbound_data_t'(s[i]) != CHAR_CR) begin
                bad = 1'b1;
            end
        end
        return (bad || digits != INSTR_DIGITS) ? 0 : ones;
    endfunction

    task automatic queue_line(input string s);
        for (int i = 0; i < s.len(); i++) tx_q.push_back(inbound_data_t'(s[i]));
        tx_q.push_back(CHAR_LF);
        if (!model_eof) exp_sum = exp_sum + result_t'(line_weight(s));
    endtask

    task automatic queue_eot();
        tx_q.push_back(CHAR_EOT);
        model_eof = 1'b1;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge tck);
    endtask

    // One DR scan: junk bypass bit, queued bytes LSB first, optional stray bits
    task automatic dr_write(input int tail_bits);
        inbound_data_t b;
        logic [31:0]   r;
        logic          seen_error;
        @(posedge tck);
        capture_dr <= 1'b1;
        @(posedge tck);
        capture_dr <= 1'b0;
        shift_dr   <= 1'b1;
        tdi        <= 1'b1;
        while (tx_q.size() > 0) begin
            b = tx_q.pop_front();
            for (int i = 0; i < 8; i++) begin
                @(posedge tck);
                tdi <= b[i];
            end
        end
        for (int i = 0; i < tail_bits; i++) begin
            r = lcg_next();
            @(posedge tck);
            tdi <= r[16];
        end
        @(posedge tck);
        shift_dr  <= 1'b0;
        update_dr <= 1'b1;
        tdi       <= 1'b0;
        @(posedge tck);
        update_dr <= 1'b0;
        @(negedge tck);
        seen_error = alignment_error;
        compare_bit("alignment_error", seen_error, logic'(tail_bits != 0));
        idle(4);
    endtask

    // 25-bit readback; TDI carries line feeds so the parser stays at a line boundary
    task automatic dr_read(output logic final_bit, output result_t value);
        logic [24:0]   bits;
        inbound_data_t fill;
        fill = CHAR_LF;
        @(posedge tck);
        capture_dr <= 1'b1;
        @(posedge tck);
        capture_dr <= 1'b0;
        shift_dr   <= 1'b1;
        tdi        <= 1'b0;
        for (int i = 0; i < 25; i++) begin
            @(negedge tck);
            bits[i] = tdo;
            @(posedge tck);
            if (i == 24) begin
                shift_dr  <= 1'b0;
                update_dr <= 1'b1;
            end else begin
                tdi <= fill[i % 8];
            end
        end
        @(posedge tck);
        update_dr <= 1'b0;
        final_bit = bits[0];
        value     = bits[24:1];
        idle(4);
    endtask

    task automatic read_and_compare(input logic exp_final, input result_t exp_value);
        logic    got_final;
        result_t got_value;
        dr_read(got_final, got_value);
        compare_bit("final", got_final, exp_final);
        compare_result("result", got_value, exp_value);
    endtask

    // Session clear through test_logic_reset or a dropped USER instruction
    task automatic clear_session(input logic use_tlr);
        @(posedge tck);
        if (use_tlr) test_logic_reset <= 1'b1;
        else ir_is_user <= 1'b0;
        @(posedge tck);
        test_logic_reset <= 1'b0;
        ir_is_user       <= 1'b1;
        idle(3);
        exp_sum   = '0;
        model_eof = 1'b0;
    endtask

    task automatic accept_valid_lines();
        queue_line("0123456789a");
        queue_line("fffffffffff\015");
        queue_line("AbCdEf01234");
        queue_eot();
        dr_write(0);
        read_and_compare(1'b1, exp_sum);
    endtask

    task automatic reject_malformed_lines();
        clear_session(1'b1);
        queue_line("0123456789a");
        queue_line("01234g6789a");
        queue_line("0123456789");
        queue_line("0123456789ab");
        queue_line("76543210FED");
        queue_eot();
        dr_write(0);
        read_and_compare(1'b1, exp_sum);
    endtask

    task automatic recover_after_partial_byte();
        clear_session(1'b1);
        queue_line("00000000fff");
        dr_write(5);
        queue_line("123456789ab");
        queue_eot();
        dr_write(0);
        read_and_compare(1'b1, exp_sum);
    endtask

    task automatic tally_random_lines();
        string         s;
        string         hex_lower;
        logic [31:0]   r;
        inbound_data_t c;
        hex_lower = "0123456789abcdef";
        clear_session(1'b1);
        for (int n = 0; n < 20; n++) begin
            s = "00000000000";
            for (int d = 0; d < INSTR_DIGITS; d++) begin
                r = lcg_next();
                c = inbound_data_t'(hex_lower[r[19:16]]);
                if (r[20] && c >= "a") c = c - 8'd32;
                s.putc(d, c);
            end
            queue_line(s);
            // Flush a scan every few lines
            if (tx_q.size() >= 30) dr_write(0);
        end
        queue_eot();
        dr_write(0);
        read_and_compare(1'b1, exp_sum);
        // Bytes after EOT, a second EOT among them, leave the readback alone
        queue_line("fffffffffff");
        queue_line("0f0f0f0f0f0");
        queue_eot();
        dr_write(0);
        read_and_compare(1'b1, exp_sum);
    endtask

    task automatic restart_after_session_clear();
        clear_session(1'b0);
        read_and_compare(1'b0, '0);
        queue_line("fedcba98765");
        queue_line("13579bdf024");
        queue_eot();
        dr_write(0);
        read_and_compare(1'b1, exp_sum);
    endtask

    initial begin
        tck              = 1'b0;
        rst_n            = 1'b0;
        tdi              = 1'b0;
        test_logic_reset = 1'b0;
        ir_is_user       = 1'b1;
        capture_dr       = 1'b0;
        shift_dr         = 1'b0;
        update_dr        = 1'b0;
        exp_sum          = '0;
        model_eof        = 1'b0;
        lcg_state        = 32'h344d;
        cycles           = 0;
        repeat (5) @(posedge tck);
        rst_n <= 1'b1;
        idle(2);
        read_and_compare(1'b0, '0);
        accept_valid_lines();
        reject_malformed_lines();
        recover_after_partial_byte();
        tally_random_lines();
        restart_after_session_clear();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
verilog/jtag_user_pkg.sv
verilog/tap_decoder.sv
verilog/line_decoder.sv
verilog/instr_tally.sv
verilog/tap_encoder.sv
verilog/user_logic.sv
dv/user_logic_checker.sv
dv/user_logic_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f flist.f --top-module user_logic_tb -o sim \
    && ./obj_dir/sim \
    || exit 1

/* verilog/instr_tally.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_tally
    import jtag_user_pkg::*;
(
    input  logic    tck,
    input  logic    rst_n,
    input  logic    session_clear,
    input  logic    digit_shift,
    input  nibble_t digit_value,
    input  logic    commit,
    input  logic    line_start_clear,
    output result_t result
);

    instr_t  instr;
    result_t instr_ones;

    assign instr_ones = result_t'($countones(instr));

    // First digit ends up as the most significant nibble
    always_ff @(posedge tck) begin
        if (session_clear || line_start_clear) begin
            instr <= '0;
        end else if (digit_shift) begin
            instr <= {instr[$bits(instr_t)-5:0], digit_value};
        end
    end

    // Commit sees the full line before line_start_clear empties it
    always_ff @(posedge tck) begin
        if (!rst_n) begin
            result <= '0;
        end else if (session_clear) begin
            result <= '0;
        end else if (commit) begin
            result <= result + instr_ones;
        end
    end

endmodule

`default_nettype wire

/* verilog/jtag_user_pkg.sv */
`default_nettype none

package jtag_user_pkg;

    // Digits per instruction line
    localparam int INSTR_DIGITS = 11;

    // One received character from the DR path
    typedef logic [7:0] inbound_data_t;

    // Value of one hex digit
    typedef logic [3:0] nibble_t;

    // Normalized instruction, one nibble per digit
    typedef logic [INSTR_DIGITS*4-1:0] instr_t;

    // Accumulated set-bit count
    typedef logic [23:0] result_t;

    // Digits seen on the current line
    typedef logic [3:0] digit_count_t;

    // Control characters of the text stream
    localparam inbound_data_t CHAR_LF  = 8'h0a;
    localparam inbound_data_t CHAR_CR  = 8'h0d;
    localparam inbound_data_t CHAR_EOT = 8'h04;

    // Line parser states
    typedef enum logic [1:0] {
        line_start,
        in_digits,
        discard_line,
        file_done
    } line_state_t;

endpackage

`default_nettype wire

/* verilog/line_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module line_decoder
    import jtag_user_pkg::*;
(
    input  logic          tck,
    input  logic          rst_n,
    input  logic          test_logic_reset,
    input  logic          ir_is_user,
    input  logic          inbound_valid,
    input  inbound_data_t inbound_data,
    output logic          session_clear,
    output logic          digit_shift,
    output nibble_t       digit_value,
    output logic          commit,
    output logic          line_start_clear,
    output logic          end_of_file
);

    line_state_t  state;
    digit_count_t digit_cnt;
    logic         is_hex;
    nibble_t      hex_nibble;
    logic         is_lf;
    logic         is_cr;
    logic         is_eot;
    logic         line_full;

    // Character classification
    always_comb begin
        is_hex     = 1'b1;
        hex_nibble = '0;
        if (inbound_data >= "0" && inbound_data <= "9") begin
            hex_nibble = nibble_t'(inbound_data - "0");
        end else if (inbound_data >= "a" && inbound_data <= "f") begin
            hex_nibble = nibble_t'(inbound_data - "a" + 8'd10);
        end else if (inbound_data >= "A" && inbound_data <= "F") begin
            hex_nibble = nibble_t'(inbound_data - "A" + 8'd10);
        end else begin
            is_hex = 1'b0;
        end
    end

    assign is_lf     = inbound_data == CHAR_LF;
    assign is_cr     = inbound_data == CHAR_CR;
    assign is_eot    = inbound_data == CHAR_EOT;
    assign line_full = digit_cnt == digit_count_t'(INSTR_DIGITS);

    always_ff @(posedge tck) begin
        if (!rst_n) begin
            state            <= line_start;
            digit_cnt        <= '0;
            session_clear    <= 1'b0;
            digit_shift      <= 1'b0;
            commit           <= 1'b0;
            line_start_clear <= 1'b0;
            end_of_file      <= 1'b0;
        end else begin
            session_clear    <= test_logic_reset || !ir_is_user;
            digit_shift      <= 1'b0;
            commit           <= 1'b0;
            line_start_clear <= 1'b0;
            end_of_file      <= 1'b0;
            if (session_clear) begin
                state     <= line_start;
                digit_cnt <= '0;
            end else if (inbound_valid) begin
                case (state)
                    line_start, in_digits: begin
                        if (is_hex) begin
                            if (line_full) begin
                                // Twelfth digit spoils the line
                                state <= discard_line;
                            end else begin
                                digit_shift <= 1'b1;
                                digit_cnt   <= digit_cnt + 1'b1;
                                state       <= in_digits;
                            end
                        end else if (is_lf) begin
                            commit           <= line_full;
                            line_start_clear <= 1'b1;
                            digit_cnt        <= '0;
                            state            <= line_start;
                        end else if (is_eot) begin
                            end_of_file <= 1'b1;
                            state       <= file_done;
                        end else if (!is_cr) begin
                            state <= discard_line;
                        end
                    end
                    discard_line: begin
                        if (is_lf) begin
                            line_start_clear <= 1'b1;
                            digit_cnt        <= '0;
                            state            <= line_start;
                        end else if (is_eot) begin
                            end_of_file <= 1'b1;
                            state       <= file_done;
                        end
                    end
                    // Stays here until the session is cleared
                    file_done: ;
                    default: state <= line_start;
                endcase
            end
        end
    end

    always_ff @(posedge tck) begin
        if (inbound_valid && is_hex) begin
            digit_value <= hex_nibble;
        end
    end

endmodule

`default_nettype wire

/* verilog/tap_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module tap_decoder
    import jtag_user_pkg::*;
#(
    parameter int UPSTREAM_BYPASS_BITS = 1
) (
    input  logic          tck,
    input  logic          rst_n,
    input  logic          tdi,
    input  logic          ir_is_user,
    input  logic          shift_dr,
    input  logic          update_dr,
    input  logic          session_clear,
    output logic          inbound_valid,
    output inbound_data_t inbound_data,
    output logic          alignment_error
);

    localparam int BYTE_W      = $bits(inbound_data_t);
    localparam int BIT_CNT_W   = $clog2(BYTE_W);
    localparam int BYPASS_CNT_W =
        (UPSTREAM_BYPASS_BITS > 0) ? $clog2(UPSTREAM_BYPASS_BITS + 1) : 1;
    localparam logic [BIT_CNT_W-1:0] LAST_BIT = BIT_CNT_W'(BYTE_W - 1);

    logic [BYPASS_CNT_W-1:0] bypass_cnt;
    logic [BIT_CNT_W-1:0]    bit_cnt;
    inbound_data_t           shift_byte;
    inbound_data_t           next_byte;
    logic                    sample;
    logic                    bypass_done;

    assign sample      = shift_dr && ir_is_user;
    assign bypass_done = int'(bypass_cnt) >= UPSTREAM_BYPASS_BITS;
    // LSB arrives first, so new bits enter at the top
    assign next_byte   = {tdi, shift_byte[BYTE_W-1:1]};

    always_ff @(posedge tck) begin
        if (!rst_n) begin
            bypass_cnt      <= '0;
            bit_cnt         <= '0;
            inbound_valid   <= 1'b0;
            alignment_error <= 1'b0;
        end else begin
            inbound_valid   <= 1'b0;
            alignment_error <= 1'b0;
            if (session_clear) begin
                bypass_cnt <= '0;
                bit_cnt    <= '0;
            end else if (update_dr && ir_is_user) begin
                // Partial byte is dropped here
                alignment_error <= (bit_cnt != '0);
                bypass_cnt      <= '0;
                bit_cnt         <= '0;
            end else if (sample) begin
                if (!bypass_done) begin
                    bypass_cnt <= bypass_cnt + 1'b1;
                end else begin
                    bit_cnt       <= bit_cnt + 1'b1;
                    inbound_valid <= (bit_cnt == LAST_BIT);
                end
            end
        end
    end

    always_ff @(posedge tck) begin
        if (sample && bypass_done) begin
            shift_byte <= next_byte;
            if (bit_cnt == LAST_BIT) begin
                inbound_data <= next_byte;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/tap_encoder.sv */
`timescale 1ns/10ps
`default_nettype none

module tap_encoder
    import jtag_user_pkg::*;
(
    input  logic    tck,
    input  logic    rst_n,
    input  logic    session_clear,
    input  logic    end_of_file,
    input  result_t result,
    input  logic    ir_is_user,
    input  logic    capture_dr,
    input  logic    shift_dr,
    output logic    tdo
);

    localparam int DR_W = $bits(result_t) + 1;

    logic            final_flag;
    result_t         held_result;
    logic [DR_W-1:0] dr_shift;

    // Result is frozen once the file has ended
    always_ff @(posedge tck) begin
        if (!rst_n) begin
            final_flag  <= 1'b0;
            held_result <= '0;
        end else if (session_clear) begin
            final_flag  <= 1'b0;
            held_result <= '0;
        end else if (end_of_file) begin
            final_flag  <= 1'b1;
            held_result <= result;
        end
    end

    // Flag goes out first, then the result LSB first
    always_ff @(posedge tck) begin
        if (!rst_n) begin
            dr_shift <= '0;
        end else if (capture_dr && ir_is_user) begin
            dr_shift <= {held_result, final_flag};
        end else if (shift_dr && ir_is_user) begin
            dr_shift <= {1'b0, dr_shift[DR_W-1:1]};
        end
    end

    assign tdo = dr_shift[0];

endmodule

`default_nettype wire

/* verilog/user_logic.sv */
`timescale 1ns/10ps
`default_nettype none

module user_logic
    import jtag_user_pkg::*;
#(
    parameter int UPSTREAM_BYPASS_BITS = 1
) (
    input  logic tck,
    input  logic rst_n,
    input  logic tdi,
    input  logic test_logic_reset,
    input  logic ir_is_user,
    input  logic capture_dr,
    input  logic shift_dr,
    input  logic update_dr,
    output logic tdo,
    output logic alignment_error
);

    logic          inbound_valid;
    inbound_data_t inbound_data;
    logic          session_clear;
    logic          digit_shift;
    nibble_t       digit_value;
    logic          commit;
    logic          line_start_clear;
    logic          end_of_file;
    result_t       result;

    // Byte deserializer behind the upstream bypass bits
    tap_decoder #(
        .UPSTREAM_BYPASS_BITS(UPSTREAM_BYPASS_BITS)
    ) tap_decoder_i (
        .tck            (tck),
        .rst_n          (rst_n),
        .tdi            (tdi),
        .ir_is_user     (ir_is_user),
        .shift_dr       (shift_dr),
        .update_dr      (update_dr),
        .session_clear  (session_clear),
        .inbound_valid  (inbound_valid),
        .inbound_data   (inbound_data),
        .alignment_error(alignment_error)
    );

    line_decoder line_decoder_i (
        .tck             (tck),
        .rst_n           (rst_n),
        .test_logic_reset(test_logic_reset),
        .ir_is_user      (ir_is_user),
        .inbound_valid   (inbound_valid),
        .inbound_data    (inbound_data),
        .session_clear   (session_clear),
        .digit_shift     (digit_shift),
        .digit_value     (digit_value),
        .commit          (commit),
        .line_start_clear(line_start_clear),
        .end_of_file     (end_of_file)
    );

    instr_tally instr_tally_i (
        .tck             (tck),
        .rst_n           (rst_n),
        .session_clear   (session_clear),
        .digit_shift     (digit_shift),
        .digit_value     (digit_value),
        .commit          (commit),
        .line_start_clear(line_start_clear),
        .result          (result)
    );

    // Readback of flag and result on TDO
    tap_encoder tap_encoder_i (
        .tck          (tck),
        .rst_n        (rst_n),
        .session_clear(session_clear),
        .end_of_file  (end_of_file),
        .result       (result),
        .ir_is_user   (ir_is_user),
        .capture_dr   (capture_dr),
        .shift_dr     (shift_dr),
        .tdo          (tdo)
    );

endmodule

`default_nettype wire
